// File: geom_pkg.sv
// Field geometry for the road crossing game
// Coordinate types, field limits, lane layout and start positions

package geom_pkg;

    // Column and row coordinates of the 160 by 120 field
    typedef logic [7:0] x_t;
    typedef logic [6:0] y_t;

    typedef struct packed {
        x_t x;
        y_t y;
    } pos_t;

    // Field limits
    localparam x_t max_x = 8'd159;
    localparam y_t max_y = 7'd119;

    // Bottom rows from here down are the safe zone
    localparam y_t safe_y_min = 7'd100;

    // Player enters at the bottom centre
    localparam pos_t player_start = '{x: 8'd80, y: 7'd119};

    // Car i drives in row lane_first + i * lane_gap
    localparam int unsigned lane_first = 5;
    localparam int unsigned lane_gap = 10;

    // Car i starts at column i * car_stagger
    localparam int unsigned car_stagger = 16;

endpackage

// File: game_pkg.sv
// Game state types for the road crossing game
// Lives, score, key moves, visible status and referee phase

package game_pkg;

    typedef logic [3:0] lives_t;
    typedef logic [7:0] score_t;

    // Keys, active high
    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
    } move_t;

    // What the outside world sees of the game
    typedef struct packed {
        logic   playing;
        lives_t lives;
        score_t score;
    } status_t;

    // Referee phases
    typedef enum logic {
        phase_setup,
        phase_play
    } phase_t;

endpackage

// File: tick_divider.sv
// Game pace divider
// Emits a one-cycle tick every period cycles while the game is playing

`timescale 1ns/10ps

module tick_divider #(
    parameter int period = 4
) (
    input  logic clock,
    input  logic rst_n,
    input  logic playing,
    output logic tick
);

    localparam int cnt_w = (period > 1) ? $clog2(period) : 1;

    logic [cnt_w-1:0] count;

    // Last cycle of each period, only in play
    assign tick = playing && (count == cnt_w'(period - 1));

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            count <= '0;
        end
        else if (!playing || tick)
        begin
            count <= '0;
        end
        else
        begin
            count <= count + 1'b1;
        end
    end

    if (period > 1)
    begin : g_tick_check
        // Ticks are spaced out whenever the period allows it
        a_tick_single : assert property (
            @(posedge clock) disable iff (!rst_n) tick |=> !tick
        );
    end

endmodule

// File: player_mover.sv
// Player mover
// Steps the player one square per tick from the keys, kept inside the field

`timescale 1ns/10ps

module player_mover import geom_pkg::*, game_pkg::*; #(
    parameter int period = 4
) (
    input  logic  clock,
    input  logic  rst_n,
    input  logic  playing,
    input  logic  restart,
    input  move_t keys,
    output pos_t  player_pos
);

    logic tick;
    pos_t step;

    tick_divider #(
        .period(period)
    ) i_tick_divider (
        .clock  (clock),
        .rst_n  (rst_n),
        .playing(playing),
        .tick   (tick)
    );

    // Pick the first pressed direction, then drop the step at an edge
    always_comb
    begin
        step = player_pos;
        if (keys.up)
        begin
            if (player_pos.y != '0)
            begin
                step.y = player_pos.y - 1'b1;
            end
        end
        else if (keys.down)
        begin
            if (player_pos.y != max_y)
            begin
                step.y = player_pos.y + 1'b1;
            end
        end
        else if (keys.left)
        begin
            if (player_pos.x != '0)
            begin
                step.x = player_pos.x - 1'b1;
            end
        end
        else if (keys.right)
        begin
            if (player_pos.x != max_x)
            begin
                step.x = player_pos.x + 1'b1;
            end
        end
    end

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            player_pos <= player_start;
        end
        else if (!playing || restart)
        begin
            // Back to the start on a hit, a win or outside play
            player_pos <= player_start;
        end
        else if (tick)
        begin
            player_pos <= step;
        end
    end

    a_player_in_field : assert property (
        @(posedge clock) disable iff (!rst_n)
        player_pos.x <= max_x && player_pos.y <= max_y
    );

endmodule

// File: traffic_mover.sv
// Traffic mover
// Advances every car one column per tick in its fixed lane, wrapping at the right edge

`timescale 1ns/10ps

module traffic_mover import geom_pkg::*; #(
    parameter int num_cars = 4,
    parameter int period = 3
) (
    input  logic clock,
    input  logic rst_n,
    input  logic playing,
    output pos_t car_pos [num_cars]
);

    logic tick;
    x_t   car_x [num_cars];

    tick_divider #(
        .period(period)
    ) i_tick_divider (
        .clock  (clock),
        .rst_n  (rst_n),
        .playing(playing),
        .tick   (tick)
    );

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int k = 0; k < num_cars; k++)
            begin
                car_x[k] <= x_t'(k * car_stagger);
            end
        end
        else if (!playing)
        begin
            // Cars wait at their start columns between games
            for (int k = 0; k < num_cars; k++)
            begin
                car_x[k] <= x_t'(k * car_stagger);
            end
        end
        else if (tick)
        begin
            for (int k = 0; k < num_cars; k++)
            begin
                car_x[k] <= (car_x[k] == max_x) ? '0 : car_x[k] + 1'b1;
            end
        end
    end

    for (genvar i = 0; i < num_cars; i++)
    begin : g_car
        // Lane row depends only on the car index
        assign car_pos[i].x = car_x[i];
        assign car_pos[i].y = y_t'(lane_first + i * lane_gap);

        // Car columns stay inside the field
        a_car_on_road : assert property (
            @(posedge clock) disable iff (!rst_n)
            car_pos[i].x <= max_x
        );
    end

endmodule

// File: referee.sv
// Game referee
// Setup and play FSM, hit and win detection, lives and score keeping

`timescale 1ns/10ps

module referee import geom_pkg::*, game_pkg::*; #(
    parameter int num_cars = 4
) (
    input  logic    clock,
    input  logic    rst_n,
    input  lives_t  lives_sw,
    input  logic    go,
    input  pos_t    player_pos,
    input  pos_t    car_pos [num_cars],
    output logic    restart,
    output status_t status
);

    phase_t phase;
    logic   armed;
    lives_t lives;
    score_t score;
    logic   playing;
    logic   hit;
    logic   win;

    assign playing = (phase == phase_play);

    // Player on the same square as any car
    always_comb
    begin
        hit = 1'b0;
        for (int k = 0; k < num_cars; k++)
        begin
            if (car_pos[k] == player_pos)
            begin
                hit = 1'b1;
            end
        end
    end

    assign win = (player_pos.y == '0);

    assign restart = playing && (hit || win);

    assign status = '{playing: playing, lives: lives, score: score};

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            phase <= phase_setup;
            armed <= 1'b0;
            lives <= '0;
            score <= '0;
        end
        else
        begin
            case (phase)
                phase_setup:
                begin
                    if (go)
                    begin
                        armed <= 1'b1;
                    end
                    else if (armed)
                    begin
                        // Release of go loads the new game
                        armed <= 1'b0;
                        lives <= lives_sw;
                        score <= '0;
                        if (lives_sw != '0)
                        begin
                            phase <= phase_play;
                        end
                    end
                end
                phase_play:
                begin
                    if (hit)
                    begin
                        lives <= lives - 1'b1;
                        if (lives == lives_t'(1))
                        begin
                            phase <= phase_setup;
                        end
                    end
                    else if (win)
                    begin
                        score <= score + 1'b1;
                    end
                end
                default:
                begin
                    phase <= phase_setup;
                end
            endcase
        end
    end

    // A running game always has a life left
    a_lives_in_play : assert property (
        @(posedge clock) disable iff (!rst_n)
        status.playing |-> status.lives != '0
    );

endmodule

// File: road_crosser.sv
// Road crossing game core
// Player and traffic movers side by side, judged by the referee

`timescale 1ns/10ps

module road_crosser import geom_pkg::*, game_pkg::*; #(
    parameter int num_cars = 4,
    parameter int player_period = 4,
    parameter int car_period = 3
) (
    input  logic    clock,
    input  logic    rst_n,
    input  lives_t  lives_sw,
    input  logic    go,
    input  move_t   keys,
    output pos_t    player_pos,
    output pos_t    car_pos [num_cars],
    output status_t status
);

    logic restart;

    player_mover #(
        .period(player_period)
    ) i_player_mover (
        .clock     (clock),
        .rst_n     (rst_n),
        .playing   (status.playing),
        .restart   (restart),
        .keys      (keys),
        .player_pos(player_pos)
    );

    traffic_mover #(
        .num_cars(num_cars),
        .period  (car_period)
    ) i_traffic_mover (
        .clock  (clock),
        .rst_n  (rst_n),
        .playing(status.playing),
        .car_pos(car_pos)
    );

    // Referee sees both movers and drives the game status
    referee #(
        .num_cars(num_cars)
    ) i_referee (
        .clock     (clock),
        .rst_n     (rst_n),
        .lives_sw  (lives_sw),
        .go        (go),
        .player_pos(player_pos),
        .car_pos   (car_pos),
        .restart   (restart),
        .status    (status)
    );

endmodule

// File: tb_model.svh
// Cycle model of the road crossing game
// Pace dividers, player, traffic and referee stepped once per clock edge

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Field and layout as the game rules define them
localparam int field_cols = 160;
localparam int field_rows = 120;
localparam int start_col = 80;
localparam int start_row = 119;
localparam int lane_row0 = 5;
localparam int lane_spacing = 10;
localparam int car_spacing = 16;

int     p_count;
int     c_count;
logic   m_playing;
logic   m_armed;
lives_t m_lives;
score_t m_score;
pos_t   m_player;
pos_t   m_cars [num_cars];

function automatic y_t lane_row(input int idx);
    return y_t'(lane_row0 + idx * lane_spacing);
endfunction

function automatic pos_t car_home(input int idx);
    pos_t p;
    p.x = x_t'(idx * car_spacing);
    p.y = lane_row(idx);
    return p;
endfunction

function automatic pos_t player_home();
    pos_t p;
    p.x = x_t'(start_col);
    p.y = y_t'(start_row);
    return p;
endfunction

// One step in the first pressed direction, refused at the field border
function automatic pos_t model_move(input pos_t p, input move_t k);
    int   col;
    int   row;
    pos_t q;
    col = int'(p.x);
    row = int'(p.y);
    if (k.up)
    begin
        row = row - 1;
    end
    else if (k.down)
    begin
        row = row + 1;
    end
    else if (k.left)
    begin
        col = col - 1;
    end
    else if (k.right)
    begin
        col = col + 1;
    end
    q = p;
    if (row >= 0 && row < field_rows && col >= 0 && col < field_cols)
    begin
        q.x = x_t'(col);
        q.y = y_t'(row);
    end
    return q;
endfunction

task automatic model_reset();
    p_count = 0;
    c_count = 0;
    m_playing = 1'b0;
    m_armed = 1'b0;
    m_lives = '0;
    m_score = '0;
    m_player = player_home();
    for (int i = 0; i < num_cars; i++)
    begin
        m_cars[i] = car_home(i);
    end
endtask

task automatic model_step(input lives_t sw, input logic go_in, input move_t k);
    logic p_tick;
    logic c_tick;
    logic hit;
    logic win;
    logic back;
    p_tick = m_playing && (p_count == player_period - 1);
    c_tick = m_playing && (c_count == car_period - 1);
    hit = 1'b0;
    for (int i = 0; i < num_cars; i++)
    begin
        if (m_cars[i] == m_player)
        begin
            hit = 1'b1;
        end
    end
    win = (m_player.y == 0);
    back = m_playing && (hit || win);

    // Movers and dividers see the game state from before this edge
    if (!m_playing || back)
    begin
        m_player = player_home();
    end
    else if (p_tick)
    begin
        m_player = model_move(m_player, k);
    end
    for (int i = 0; i < num_cars; i++)
    begin
        if (!m_playing)
        begin
            m_cars[i] = car_home(i);
        end
        else if (c_tick)
        begin
            m_cars[i].x = x_t'((int'(m_cars[i].x) + 1) % field_cols);
        end
    end
    p_count = m_playing ? (p_count + 1) % player_period : 0;
    c_count = m_playing ? (c_count + 1) % car_period : 0;

    // Referee last, it changes m_playing
    if (!m_playing)
    begin
        if (go_in)
        begin
            m_armed = 1'b1;
        end
        else if (m_armed)
        begin
            m_armed = 1'b0;
            m_lives = sw;
            m_score = '0;
            m_playing = (sw != 0);
        end
    end
    else if (hit)
    begin
        if (m_lives == 1)
        begin
            m_playing = 1'b0;
        end
        m_lives = m_lives - 4'd1;
    end
    else if (win)
    begin
        m_score = m_score + 8'd1;
    end
endtask

`endif

// File: tb_road_crosser.sv
// Testbench for the road crossing game core
// LFSR driven games with every output checked each cycle against a cycle model

`timescale 1ns/10ps

module tb_road_crosser import geom_pkg::*, game_pkg::*;;

    localparam int num_cars = 4;
    localparam int player_period = 4;
    localparam int car_period = 3;
    localparam int clock_period = 40;
    localparam int num_games = 8;

    // Per life a slow climb plus one full traffic sweep for up to 15 lives
    localparam int climb_cycles = 119 * player_period * 3;
    localparam int sweep_cycles = 160 * car_period;
    localparam int game_cycles = 15 * (climb_cycles + sweep_cycles) + 16;
    localparam longint timeout_ns =
        longint'(num_games + 1) * longint'(game_cycles) * longint'(clock_period);

    logic    clock = 1'b0;
    logic    rst_n;
    lives_t  lives_sw;
    logic    go;
    move_t   keys;
    pos_t    player_pos;
    pos_t    car_pos [num_cars];
    status_t status;

    logic [31:0] lfsr_state;
    int          games_done;

    `include "tb_model.svh"

    road_crosser #(
        .num_cars     (num_cars),
        .player_period(player_period),
        .car_period   (car_period)
    ) i_road_crosser (
        .clock     (clock),
        .rst_n     (rst_n),
        .lives_sw  (lives_sw),
        .go        (go),
        .keys      (keys),
        .player_pos(player_pos),
        .car_pos   (car_pos),
        .status    (status)
    );

    always #(clock_period / 2) clock = ~clock;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0])
        begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("Fail %s expected %0h actual %0h", name, expected, actual);
        $display(">>> FAIL");
        $fatal(1, "mismatch on %s", name);
    endtask

    task automatic report_problem(input string what);
        $display("Error: %s", what);
        $display(">>> FAIL");
        $fatal(1, "%s", what);
    endtask

    task automatic check_outputs();
        status_t want;
        want.playing = m_playing;
        want.lives = m_lives;
        want.score = m_score;
        assert (player_pos === m_player)
        else report_mismatch("player_pos", {17'b0, m_player}, {17'b0, player_pos});
        for (int i = 0; i < num_cars; i++)
        begin
            assert (car_pos[i] === m_cars[i])
            else report_mismatch($sformatf("car_pos[%0d]", i), {17'b0, m_cars[i]},
                                 {17'b0, car_pos[i]});
        end
        assert (status === want)
        else report_mismatch("status", {19'b0, want}, {19'b0, status});
    endtask

    // Up three times in four while the other directions test the priority
    task automatic choose_keys();
        logic [31:0] r;
        move_t       k;
        draw_bits(2, r);
        k.up = (r[1:0] != 2'b00);
        draw_bits(3, r);
        k.down = r[2];
        k.left = r[1];
        k.right = r[0];
        // After a crossing, wait in the lowest lane until a car hits
        if (m_score[0] && m_player.y == lane_row(num_cars - 1))
        begin
            k = '0;
        end
        keys <= k;
    endtask

    // Model sees the inputs that the DUT samples at this edge
    task automatic next_cycle();
        @(posedge clock);
        if (!rst_n)
        begin
            model_reset();
        end
        else
        begin
            model_step(lives_sw, go, keys);
        end
        if (m_playing && p_count == player_period - 1)
        begin
            choose_keys();
        end
    endtask

    task automatic press_go(input lives_t value, input int hold);
        next_cycle();
        lives_sw <= value;
        go <= 1'b1;
        repeat (hold) next_cycle();
        go <= 1'b0;
        next_cycle();
    endtask

    always @(negedge clock)
    begin
        check_outputs();
    end

    initial
    begin : watchdog
        #(timeout_ns);
        $display("Timeout: the games did not finish in the expected time");
        $display(">>> FAIL");
        $fatal(1, "watchdog expired");
    end

    initial
    begin : stimulus
        logic [31:0] r;
        lives_t      pick;
        int          hold;
        rst_n = 1'b0;
        lives_sw = '0;
        go = 1'b0;
        keys = '0;
        lfsr_state = 32'h98e3_4720;
        games_done = 0;
        model_reset();
        repeat (10) next_cycle();
        rst_n <= 1'b1;
        repeat (3) next_cycle();

        // Zero lives stays in setup
        press_go(4'd0, 2);
        repeat (4) next_cycle();
        @(negedge clock);
        assert (status.playing === 1'b0)
        else report_problem("a game started with zero lives on the switches");

        while (games_done < num_games)
        begin
            draw_bits(4, r);
            pick = r[3:0];
            draw_bits(2, r);
            hold = int'(r[1:0]) + 1;
            press_go(pick, hold);
            if (m_playing)
            begin
                while (m_playing)
                begin
                    next_cycle();
                end
                games_done++;
            end
        end
        repeat (2) next_cycle();
        $display(">>> PASS");
        $finish;
    end

endmodule

// File: flist.f
+incdir+.
geom_pkg.sv
game_pkg.sv
tick_divider.sv
player_mover.sv
traffic_mover.sv
referee.sv
road_crosser.sv
tb_road_crosser.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_road_crosser
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)
